/* aes_key_mem.f */
+incdir+include
hw/aes_pkgs.sv
hw/key_step_if.sv
hw/aes_sbox_word.sv
hw/key_sched_ctrl.sv
hw/round_ctr.sv
hw/round_key_gen.sv
hw/round_key_store.sv
hw/aes_key_mem.sv
testbench/aes_key_mem_chk.sv
testbench/tb_aes_key_mem.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_aes_key_mem
FILELIST  = aes_key_mem.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: run clean

# build, simulate, then decide on the pass line in the log
run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/aes_key_mem_tests.txt */
# K len key : load a 256-bit key field, len 0 = AES-128 in the upper half, 1 = AES-256
# R round expected : read one round key; B : init_valid while the next key expands
K 0 2b7e151628aed2a6abf7158809cf4f3c0123456789abcdeffedcba9876543210
R 0 2b7e151628aed2a6abf7158809cf4f3c
R 1 a0fafe1788542cb123a339392a6c7605
R 2 f2c295f27a96b9435935807a7359f67f
R 3 3d80477d4716fe3e1e237e446d7a883b
R 4 ef44a541a8525b7fb671253bdb0bad00
R 5 d4d1c6f87c839d87caf2b8bc11f915bc
R 6 6d88a37a110b3efddbf98641ca0093fd
R 7 4e54f70e5f5fc9f384a64fb24ea6dc4f
R 8 ead27321b58dbad2312bf5607f8d292f
R 9 ac7766f319fadc2128d12941575c006e
R 10 d014f9a8c9ee2589e13f0cc8b6630ca6
B
K 1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
R 0 603deb1015ca71be2b73aef0857d7781
R 1 1f352c073b6108d72d9810a30914dff4
R 2 9ba354118e6925afa51a8b5f2067fcde
R 3 a8b09c1a93d194cdbe49846eb75d5b9a
R 4 d59aecb85bf3c917fee94248de8ebe96
R 5 b5a9328a2678a647983122292f6c79b3
R 6 812c81addadf48ba24360af2fab8b464
R 7 98c5bfc9bebd198e268c3ba709e04214
R 8 68007bacb2df331696e939e46c518d80
R 9 c814e20476a9fb8a5025c02d59c58239
R 10 de1369676ccc5a71fa2563959674ee15
R 11 5886ca5d2e2f31d77e0af1fa27cf73c3
R 12 749c47ab18501ddae2757e4f7401905a
R 13 cafaaae3e4d59b349adf6acebd10190d
R 14 fe4890d1e6188d0b046df344706c631e
K 0 0000000000000000000000000000000000000000000000000000000000000000
R 0 00000000000000000000000000000000
R 1 62636363626363636263636362636363
R 2 9b9898c9f9fbfbaa9b9898c9f9fbfbaa
R 3 90973450696ccffaf2f457330b0fac99
R 4 ee06da7b876a1581759e42b27e91ee2b
R 5 7f2e2b88f8443e098dda7cbbf34b9290
R 6 ec614b851425758c99ff09376ab49ba7
R 7 217517873550620bacaf6b3cc61bf09b
R 8 0ef903333ba9613897060a04511dfa9f
R 9 b1d4d8e28a7db9da1d7bb3de4c664941
R 10 b4ef5bcb3e92e21123e951cf6f8f188e
R 11 5886ca5d2e2f31d77e0af1fa27cf73c3

/* testbench/tb_aes_key_mem.sv */
//--------------------------------------------------
// file driven testbench for the AES key memory
// run from the project root, the test file path is relative
// expected round keys are FIPS-197 A.1 and A.3 plus a zero key
//--------------------------------------------------
module tb_aes_key_mem;
	timeunit 1ns;
	timeprecision 1ps;
	import aes_data_pkg::*;
	import aes_ctrl_pkg::*;

	localparam string TESTS_FILE = "testbench/aes_key_mem_tests.txt";

	logic     clk = 1'b0;
	logic     reset_n;
	key_t     key;
	key_len_t key_len;
	logic     init_valid;
	logic     init_ready;
	round_t   round_number;
	block_t   round_key;
	logic     keys_valid;

	// run bookkeeping
	int    seed = 32'hf44a;
	int    watchdog_cycles = 0;
	int    total_errors = 0;
	int    pass_count = 0;
	int    fail_count = 0;
	int    test_no = 0;
	int    test_errors = 0;
	int    test_reads = 0;
	bit    in_test = 0;
	bit    busy_pending = 0;
	string test_name;

	always #5 clk = ~clk;

	aes_key_mem i_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.key          (key),
		.key_len      (key_len),
		.init_valid   (init_valid),
		.init_ready   (init_ready),
		.round_number (round_number),
		.round_key    (round_key),
		.keys_valid   (keys_valid)
	);

	//--------------------------------------------------
	// checks and per test reporting
	//--------------------------------------------------
	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_no++;
		test_name   = name;
		test_errors = 0;
		test_reads  = 0;
		in_test     = 1;
	endtask

	task automatic end_test();
		if (test_errors == 0)
		begin
			pass_count++;
			$display("test %0d %s: ok, %0d reads", test_no, test_name, test_reads);
		end
		else
		begin
			fail_count++;
			$display("test %0d %s: %0d errors", test_no, test_name, test_errors);
		end
		in_test = 0;
	endtask

	//--------------------------------------------------
	// load one key and wait for the schedule
	//--------------------------------------------------
	task automatic start_key(input key_len_t len, input key_t k, input bit busy);
		int cycles;
		int exp_cycles;
		cycles = 0;
		// init cycle, one cycle per round key, done cycle
		exp_cycles = ((len == key_256) ? 14 : 10) + 3;
		@(negedge clk);
		check_value("init_ready", 128'(init_ready), 128'(1));
		@(posedge clk);
		key        <= k;
		key_len    <= len;
		init_valid <= 1'b1;
		// accepting edge
		@(posedge clk);
		if (busy)
		begin
			// another key right away, init_valid stays high
			key     <= ~k;
			key_len <= (len == key_256) ? key_128 : key_256;
		end
		else
		begin
			init_valid <= 1'b0;
		end
		@(negedge clk);
		check_value("keys_valid", 128'(keys_valid), 128'(0));
		while (!keys_valid)
		begin
			check_value("init_ready", 128'(init_ready), 128'(0));
			@(posedge clk);
			cycles++;
			if (busy && cycles == 9)
			begin
				init_valid <= 1'b0;
			end
			@(negedge clk);
		end
		check_value("keys_valid latency", 128'(cycles), 128'(exp_cycles));
	endtask

	task automatic read_round(input int rnd, input block_t exp);
		@(posedge clk);
		round_number <= round_t'(rnd);
		@(negedge clk);
		check_value("keys_valid", 128'(keys_valid), 128'(1));
		check_value($sformatf("round_key[%0d]", rnd), round_key, exp);
		test_reads++;
	endtask

	// a stuck handshake ends here
	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial
	begin : main
		int       fd;
		int       n;
		int       line_no;
		int       line_count;
		int       gap;
		int       len;
		int       rnd;
		key_t     kval;
		block_t   exp_key;
		string    line;
		logic [7:0] cmd;
		line_no      = 0;
		line_count   = 0;
		reset_n      = 1'b0;
		key          = '0;
		key_len      = key_128;
		init_valid   = 1'b0;
		round_number = '0;
		// size the watchdog from the test file length
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open the test file %s", TESTS_FILE);
			$display("Simulation failed");
			$finish;
		end
		while ($fgets(line, fd) > 0)
		begin
			line_count++;
		end
		$fclose(fd);
		watchdog_cycles = line_count * 40;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		begin_test("reset state");
		@(negedge clk);
		check_value("init_ready", 128'(init_ready), 128'(1));
		check_value("keys_valid", 128'(keys_valid), 128'(0));
		end_test();
		fd = $fopen(TESTS_FILE, "r");
		while ($fgets(line, fd) > 0)
		begin
			line_no++;
			if (line.len() == 0)
			begin
				continue;
			end
			cmd = line.getc(0);
			case (cmd)
				"K":
				begin
					if (in_test)
					begin
						end_test();
					end
					gap = $random(seed);
					repeat (gap & 7) @(posedge clk);
					n = $sscanf(line.substr(1, line.len() - 1), "%d %h", len, kval);
					if (n != 2)
					begin
						$display("line %0d: key line could not be read", line_no);
						total_errors++;
					end
					else
					begin
						begin_test($sformatf("AES-%0d key%s", (len != 0) ? 256 : 128,
							busy_pending ? " with init_valid while busy" : ""));
						start_key((len != 0) ? key_256 : key_128, kval, busy_pending);
					end
					busy_pending = 0;
				end
				"R":
				begin
					n = $sscanf(line.substr(1, line.len() - 1), "%d %h", rnd, exp_key);
					if (n != 2)
					begin
						$display("line %0d: read line could not be read", line_no);
						total_errors++;
					end
					else
					begin
						read_round(rnd, exp_key);
					end
				end
				"B":
				begin
					busy_pending = 1;
				end
				"#", " ", "\n", "\r":
				begin
				end
				default:
				begin
					$display("line %0d: unknown command in the test file", line_no);
					total_errors++;
				end
			endcase
		end
		$fclose(fd);
		if (in_test)
		begin
			end_test();
		end
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (total_errors == 0 && fail_count == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* testbench/aes_key_mem_chk.sv */
//--------------------------------------------------
// handshake and status properties of the key memory
// bound into every aes_key_mem instance
//--------------------------------------------------
module aes_key_mem_chk (
	input logic                       clk,
	input logic                       reset_n,
	input logic                       init_valid,
	input logic                       init_ready,
	input logic                       keys_valid,
	input aes_ctrl_pkg::sched_state_t state,
	input aes_data_pkg::round_t       round
);
	timeunit 1ns;
	timeprecision 1ps;
	import aes_data_pkg::*;
	import aes_ctrl_pkg::*;

	// busy means no valid keys
	a_busy_not_valid: assert property (@(posedge clk) disable iff (!reset_n)
		!init_ready |-> !keys_valid)
		else $error("keys_valid high while init_ready is low");

	// keys only go stale after a new key was taken
	a_fall_on_accept: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(keys_valid) |-> $past(init_valid && init_ready))
		else $error("keys_valid fell without an accepted handshake");

	a_state_known: assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown(state))
		else $error("schedule FSM state unknown");

	// store holds rounds 0 to 14 only
	a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
		round <= round_t'(14))
		else $error("round counter beyond 14");

endmodule

bind aes_key_mem aes_key_mem_chk i_chk (
	.clk        (clk),
	.reset_n    (reset_n),
	.init_valid (init_valid),
	.init_ready (init_ready),
	.keys_valid (keys_valid),
	.state      (i_ctrl.state),
	.round      (step_bus.round)
);

/* hw/aes_key_mem.sv */
//--------------------------------------------------
// AES-128 and AES-256 key schedule memory
// key and key_len are sampled on the accepting edge
// keys_valid high means every round key can be read
// round_key is only meaningful while keys_valid is high
//--------------------------------------------------
module aes_key_mem (
	input  logic                   clk,
	input  logic                   reset_n,
	input  aes_data_pkg::key_t     key,
	input  aes_ctrl_pkg::key_len_t key_len,
	input  logic                   init_valid,
	output logic                   init_ready,
	input  aes_data_pkg::round_t   round_number,
	output aes_data_pkg::block_t   round_key,
	output logic                   keys_valid
);
	import aes_data_pkg::*;

	key_t   key_r;
	word_t  sbox_in;
	word_t  sbox_out;
	block_t next_key;

	key_step_if step_bus ();

	//--------------------------------------------------
	// key held from the handshake
	//--------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			key_r <= '0;
		end
		else if (init_valid && init_ready)
		begin
			key_r <= key;
		end
	end

	//--------------------------------------------------
	// control
	//--------------------------------------------------
	key_sched_ctrl i_ctrl (
		.clk        (clk),
		.reset_n    (reset_n),
		.init_valid (init_valid),
		.init_ready (init_ready),
		.key_len_in (key_len),
		.keys_valid (keys_valid),
		.step_bus   (step_bus.ctrl)
	);

	round_ctr i_ctr (
		.clk      (clk),
		.reset_n  (reset_n),
		.step_bus (step_bus.ctr)
	);

	//--------------------------------------------------
	// datapath
	//--------------------------------------------------
	round_key_gen i_gen (
		.clk      (clk),
		.reset_n  (reset_n),
		.key      (key_r),
		.step_bus (step_bus.gen),
		.sbox_in  (sbox_in),
		.sbox_out (sbox_out),
		.next_key (next_key)
	);

	aes_sbox_word i_sbox (
		.word_in  (sbox_in),
		.word_out (sbox_out)
	);

	round_key_store i_store (
		.clk          (clk),
		.reset_n      (reset_n),
		.step_bus     (step_bus.store),
		.next_key     (next_key),
		.round_number (round_number),
		.round_key    (round_key)
	);

endmodule

/* hw/round_key_store.sv */
//--------------------------------------------------
// round key memory, rounds 0 to 14
// read is combinational, round 15 reads zero
//--------------------------------------------------
`include "aes_key_cfg.svh"

module round_key_store (
	input  logic                 clk,
	input  logic                 reset_n,
	key_step_if.store            step_bus,
	input  aes_data_pkg::block_t next_key,
	input  aes_data_pkg::round_t round_number,
	output aes_data_pkg::block_t round_key
);
	import aes_data_pkg::*;

	localparam round_t MAX_ROUND = round_t'(`AES_MAX_ROUND);

	block_t mem [0:`AES_MAX_ROUND];

	// one write per expansion step
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i <= `AES_MAX_ROUND; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (step_bus.step)
		begin
			mem[step_bus.round] <= next_key;
		end
	end

	// read port
	assign round_key = (round_number <= MAX_ROUND) ? mem[round_number] : '0;

endmodule

/* hw/round_key_gen.sv */
//--------------------------------------------------
// next round key from the two previous round keys
// key is loaded while the counter clears
// so it must stay stable until the cycle after acceptance
//--------------------------------------------------
module round_key_gen (
	input  logic                 clk,
	input  logic                 reset_n,
	input  aes_data_pkg::key_t   key,
	key_step_if.gen              step_bus,
	output aes_data_pkg::word_t  sbox_in,
	input  aes_data_pkg::word_t  sbox_out,
	output aes_data_pkg::block_t next_key
);
	import aes_data_pkg::*;
	import aes_ctrl_pkg::*;

	block_t key_hi;
	block_t key_lo;
	block_t prev_key0;
	block_t prev_key1;
	block_t base;
	block_t chained;
	word_t  rot_sub;
	word_t  xform;
	word_t  w0;
	word_t  w1;
	word_t  w2;
	word_t  w3;
	logic   is_256;
	logic   seed_round;

	assign {key_hi, key_lo} = key;
	assign is_256 = (step_bus.key_len == key_256);

	// rounds taken straight from the key, round 1 only for AES-256
	assign seed_round = (step_bus.round == '0) || (is_256 && step_bus.round == round_t'(1));

	// last word of the newest key goes through the s-box
	assign sbox_in = prev_key1[31:0];

	// rotate after sub, same result as before
	assign rot_sub = {sbox_out[23:0], sbox_out[31:24]} ^ {step_bus.rcon, 24'h0};

	//--------------------------------------------------
	// word chain
	//--------------------------------------------------
	always_comb
	begin
		if (!is_256)
		begin
			base  = prev_key1;
			xform = rot_sub;
		end
		else
		begin
			// two rounds back, odd rounds skip rotate and rcon
			base  = prev_key0;
			xform = step_bus.round[0] ? sbox_out : rot_sub;
		end
		w0      = base[127:96] ^ xform;
		w1      = base[95:64] ^ w0;
		w2      = base[63:32] ^ w1;
		w3      = base[31:0] ^ w2;
		chained = {w0, w1, w2, w3};
	end

	// round 0 upper half, AES-256 round 1 lower half
	assign next_key = !seed_round ? chained :
		(step_bus.round == '0) ? prev_key0 : prev_key1;

	//--------------------------------------------------
	// history of the last two round keys
	//--------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			prev_key0 <= '0;
			prev_key1 <= '0;
		end
		else if (step_bus.clear)
		begin
			prev_key0 <= key_hi;
			prev_key1 <= key_lo;
		end
		else if (step_bus.step)
		begin
			if (!seed_round)
			begin
				prev_key0 <= prev_key1;
				prev_key1 <= next_key;
			end
			else if (!is_256)
			begin
				// AES-128 chains from round 0
				prev_key1 <= next_key;
			end
		end
	end

endmodule

/* hw/round_ctr.sv */
//--------------------------------------------------
// round counter and rcon register
// round holds at the last round instead of wrapping
// rcon follows the FIPS-197 doubling in GF(2^8)
//--------------------------------------------------
`include "aes_key_cfg.svh"

module round_ctr (
	input  logic    clk,
	input  logic    reset_n,
	key_step_if.ctr step_bus
);
	import aes_data_pkg::*;
	import aes_ctrl_pkg::*;

	localparam round_t LAST_128 = round_t'(`AES_128_ROUNDS);
	localparam round_t LAST_256 = round_t'(`AES_256_ROUNDS);

	logic  uses_rcon;
	byte_t rcon_dbl;

	// which rounds eat an rcon value
	// AES-128 every round from 1, AES-256 only even rounds from 2
	always_comb
	begin
		if (step_bus.key_len == key_128)
		begin
			uses_rcon = (step_bus.round != '0);
		end
		else
		begin
			uses_rcon = (step_bus.round >= round_t'(2)) && !step_bus.round[0];
		end
	end

	// xtime, reduce by 1b
	assign rcon_dbl = {step_bus.rcon[6:0], 1'b0} ^ (8'h1b & {8{step_bus.rcon[7]}});

	// final round for this key length
	assign step_bus.last = (step_bus.key_len == key_128) ? (step_bus.round == LAST_128) :
		(step_bus.round == LAST_256);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			step_bus.round <= '0;
			step_bus.rcon  <= 8'h01;
		end
		else if (step_bus.clear)
		begin
			step_bus.round <= '0;
			step_bus.rcon  <= 8'h01;
		end
		else if (step_bus.step)
		begin
			if (!step_bus.last)
			begin
				step_bus.round <= round_t'(step_bus.round + 1'b1);
			end
			if (uses_rcon)
			begin
				step_bus.rcon <= rcon_dbl;
			end
		end
	end

endmodule

/* hw/key_sched_ctrl.sv */
//--------------------------------------------------
// schedule FSM with the init handshake
// init_valid is ignored while busy, nothing queues
// key length is held from the accepting edge
//--------------------------------------------------
module key_sched_ctrl (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   init_valid,
	output logic                   init_ready,
	input  aes_ctrl_pkg::key_len_t key_len_in,
	output logic                   keys_valid,
	key_step_if.ctrl               step_bus
);
	import aes_ctrl_pkg::*;

	sched_state_t state;
	sched_state_t state_nxt;
	key_len_t     key_len_r;
	logic         accept;

	// ready only when idle
	assign init_ready = (state == st_idle);
	assign accept     = init_valid && init_ready;

	// step bus outputs
	assign step_bus.clear   = (state == st_init);
	assign step_bus.step    = (state == st_generate);
	assign step_bus.key_len = key_len_r;

	//--------------------------------------------------
	// next state
	//--------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle:
			begin
				if (accept)
				begin
					state_nxt = st_init;
				end
			end
			// one cycle to clear counter and rcon
			st_init:
			begin
				state_nxt = st_generate;
			end
			// one round key per cycle
			st_generate:
			begin
				if (step_bus.last)
				begin
					state_nxt = st_done;
				end
			end
			st_done:
			begin
				state_nxt = st_idle;
			end
			default:
			begin
				state_nxt = st_idle;
			end
		endcase
	end

	//--------------------------------------------------
	// state, key length and status
	//--------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state      <= st_idle;
			key_len_r  <= key_128;
			keys_valid <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// old keys are stale once a new key is taken
			if (accept)
			begin
				key_len_r  <= key_len_in;
				keys_valid <= 1'b0;
			end
			else if (state == st_done)
			begin
				keys_valid <= 1'b1;
			end
		end
	end

endmodule

/* hw/aes_sbox_word.sv */
//--------------------------------------------------
// AES forward s-box on all four bytes of a word
// purely combinational, no latency
//--------------------------------------------------
module aes_sbox_word (
	input  aes_data_pkg::word_t word_in,
	output aes_data_pkg::word_t word_out
);
	import aes_data_pkg::*;

	// forward s-box, entry 00 in the top byte
	localparam logic [2047:0] SBOX_TBL = {
		128'h637c777b_f26b6fc5_3001672b_fed7ab76,
		128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
		128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
		128'h04c723c3_1896059a_071280e2_eb27b275,
		128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
		128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
		128'hd0efaafb_434d3385_45f9027f_503c9fa8,
		128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
		128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
		128'h60814fdc_222a9088_46eeb814_de5e0bdb,
		128'he0323a0a_4906245c_c2d3ac62_9195e479,
		128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
		128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
		128'h703eb566_4803f60e_613557b9_86c11d9e,
		128'he1f89811_69d98e94_9b1e87e9_ce5528df,
		128'h8ca1890d_bfe64268_41992d0f_b054bb16
	};

	// table lookup of one byte
	function automatic byte_t sub_byte(input byte_t b);
		return SBOX_TBL[(255 - int'(b)) * 8 +: 8];
	endfunction

	//--------------------------------------------------
	// four lookups in parallel
	//--------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			word_out[8*i +: 8] = sub_byte(word_in[8*i +: 8]);
		end
	end

endmodule

/* hw/key_step_if.sv */
//--------------------------------------------------
// one expansion step shared by the schedule blocks
// carries no clock, every register sits in the blocks
//--------------------------------------------------
interface key_step_if;
	import aes_data_pkg::*;
	import aes_ctrl_pkg::*;

	// from the FSM
	logic     step;
	logic     clear;
	key_len_t key_len;

	// from the round counter
	round_t   round;
	byte_t    rcon;
	logic     last;

	modport ctrl  (output step, clear, key_len, input last);
	modport ctr   (input step, clear, key_len, output round, rcon, last);
	modport gen   (input step, clear, key_len, round, rcon);
	// store only needs the write address
	modport store (input step, round);

endinterface

/* hw/aes_pkgs.sv */
//--------------------------------------------------
// data and control types of the key schedule
// widths come from aes_key_cfg.svh
//--------------------------------------------------
`include "aes_key_cfg.svh"

//--------------------------------------------------
// data widths
//--------------------------------------------------
package aes_data_pkg;

	// full key field, AES-128 in the upper half
	typedef logic [`AES_KEY_W-1:0] key_t;

	// one round key
	typedef logic [`AES_BLOCK_W-1:0] block_t;

	// one schedule word
	typedef logic [`AES_WORD_W-1:0] word_t;

	// s-box entries and rcon
	typedef logic [7:0] byte_t;

	// round number 0 to 14
	typedef logic [3:0] round_t;

endpackage

//--------------------------------------------------
// control encodings
//--------------------------------------------------
package aes_ctrl_pkg;

	typedef enum logic {
		key_128 = 1'b0,
		key_256 = 1'b1
	} key_len_t;

	// schedule FSM
	typedef enum logic [1:0] {
		st_idle,
		st_init,
		st_generate,
		st_done
	} sched_state_t;

endpackage

/* include/aes_key_cfg.svh */
//--------------------------------------------------
// fixed AES sizes for the key schedule memory
// only AES-128 and AES-256 key lengths exist here
// a 128-bit key sits in the upper half of the key field
//--------------------------------------------------
`ifndef AES_KEY_CFG_SVH
`define AES_KEY_CFG_SVH

// key field, wide enough for AES-256
`define AES_KEY_W 256

// one round key
`define AES_BLOCK_W 128

// one key word
`define AES_WORD_W 32

// highest round number held in the store
`define AES_MAX_ROUND 14

// last round per key length
`define AES_128_ROUNDS 10
`define AES_256_ROUNDS 14

`endif
